// ==== Makefile ====
# Verilator simulation of the AXI4-Stream bypass switch

TOP := tb_axi4s_bypass
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f \
		--top-module $(TOP) -Mdir $(OBJ)

# A failing run ends in $$fatal, so make sees a non-zero status
run: build
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ)

// ==== hw/axi4s_beat_pkg.sv ====
package axi4s_beat_pkg;

    // ============================================================
    // Stream field widths
    // ============================================================
    localparam int DATA_BYTES = 8;
    localparam int KEEP_BITS  = DATA_BYTES;
    localparam int ID_BITS    = 4;
    localparam int DEST_BITS  = 4;
    localparam int USER_BITS  = 8;

    // ============================================================
    // One AXI4-Stream beat, tvalid/tready travel beside it
    // ============================================================
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] tdata;
        logic [KEEP_BITS-1:0]       tkeep;
        logic                       tlast;
        logic [ID_BITS-1:0]         tid;
        logic [DEST_BITS-1:0]       tdest;
        logic [USER_BITS-1:0]       tuser;
    } axi4s_beat_t;

endpackage

// ==== hw/axi4s_bypass_switch.sv ====
`timescale 1ns/10ps

module axi4s_bypass_switch (
    input  logic                        axi4s_if_from_tx,
    input  logic                        aresetn,
    input  switch_cfg_pkg::path_sel_e   bypass,
    // Input stream
    input  logic                        in_valid,
    output logic                        in_ready,
    input  axi4s_beat_pkg::axi4s_beat_t in_beat,
    // Towards the external block
    output logic                        to_block_valid,
    input  logic                        to_block_ready,
    output axi4s_beat_pkg::axi4s_beat_t to_block_beat,
    // Bypass chain entry
    output logic                        bp_valid,
    input  logic                        bp_ready,
    output axi4s_beat_pkg::axi4s_beat_t bp_beat,
    // Block return, after its pipe
    input  logic                        blk_ret_valid,
    output logic                        blk_ret_ready,
    input  axi4s_beat_pkg::axi4s_beat_t blk_ret_beat,
    // Bypass chain exit
    input  logic                        bp_ret_valid,
    output logic                        bp_ret_ready,
    input  axi4s_beat_pkg::axi4s_beat_t bp_ret_beat,
    // Output stream
    output logic                        out_valid,
    input  logic                        out_ready,
    output axi4s_beat_pkg::axi4s_beat_t out_beat,
    output logic                        out_sop
);

    logic sop_q;

    // Payload fans out to both paths, valid goes to one only
    assign to_block_beat = in_beat;
    assign bp_beat       = in_beat;

    // ============================================================
    // Input steering and output 2:1 mux
    // ============================================================
    always_comb begin
        case (bypass)
            switch_cfg_pkg::PATH_BYPASS: begin
                to_block_valid = 1'b0;
                bp_valid       = in_valid;
                in_ready       = bp_ready;
                out_valid      = bp_ret_valid;
                out_beat       = bp_ret_beat;
                blk_ret_ready  = 1'b0;
                bp_ret_ready   = out_ready;
            end
            default: begin
                to_block_valid = in_valid;
                bp_valid       = 1'b0;
                in_ready       = to_block_ready;
                out_valid      = blk_ret_valid;
                out_beat       = blk_ret_beat;
                blk_ret_ready  = out_ready;
                bp_ret_ready   = 1'b0;
            end
        endcase
    end

    // ============================================================
    // Start of packet tracking
    // ============================================================
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            sop_q <= 1'b1;
        end else if (out_valid && out_ready) begin
            sop_q <= out_beat.tlast;  // next beat opens a packet after tlast
        end
    end

    assign out_sop = sop_q;

endmodule

// ==== hw/axi4s_bypass_top.sv ====
`timescale 1ns/10ps

module axi4s_bypass_top (
    input  logic                        axi4s_if_from_tx,
    input  logic                        aresetn,
    input  switch_cfg_pkg::path_sel_e   bypass,
    // Upstream source
    input  logic                        in_valid,
    output logic                        in_ready,
    input  axi4s_beat_pkg::axi4s_beat_t in_beat,
    // External processing block
    output logic                        to_block_valid,
    input  logic                        to_block_ready,
    output axi4s_beat_pkg::axi4s_beat_t to_block_beat,
    input  logic                        from_block_valid,
    output logic                        from_block_ready,
    input  axi4s_beat_pkg::axi4s_beat_t from_block_beat,
    // Downstream sink
    output logic                        out_valid,
    input  logic                        out_ready,
    output axi4s_beat_pkg::axi4s_beat_t out_beat,
    output logic                        out_sop
);

    // Bypass chain links, index 0 is the switch side entry
    logic                        chain_valid [switch_cfg_pkg::BYPASS_STAGES+1];
    logic                        chain_ready [switch_cfg_pkg::BYPASS_STAGES+1];
    axi4s_beat_pkg::axi4s_beat_t chain_beat  [switch_cfg_pkg::BYPASS_STAGES+1];

    // Block return between skid stage and register slice
    logic                        ret_mid_valid;
    logic                        ret_mid_ready;
    axi4s_beat_pkg::axi4s_beat_t ret_mid_beat;

    // Block return into the switch
    logic                        blk_ret_valid;
    logic                        blk_ret_ready;
    axi4s_beat_pkg::axi4s_beat_t blk_ret_beat;

    // ============================================================
    // Steering and output selection
    // ============================================================
    axi4s_bypass_switch switch_i (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_beat          (in_beat),
        .to_block_valid   (to_block_valid),
        .to_block_ready   (to_block_ready),
        .to_block_beat    (to_block_beat),
        .bp_valid         (chain_valid[0]),
        .bp_ready         (chain_ready[0]),
        .bp_beat          (chain_beat[0]),
        .blk_ret_valid    (blk_ret_valid),
        .blk_ret_ready    (blk_ret_ready),
        .blk_ret_beat     (blk_ret_beat),
        .bp_ret_valid     (chain_valid[switch_cfg_pkg::BYPASS_STAGES]),
        .bp_ret_ready     (chain_ready[switch_cfg_pkg::BYPASS_STAGES]),
        .bp_ret_beat      (chain_beat[switch_cfg_pkg::BYPASS_STAGES]),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_beat         (out_beat),
        .out_sop          (out_sop)
    );

    // ============================================================
    // Block return pipe, ready break then register slice
    // ============================================================
    axi4s_tready_slice ret_skid_i (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .s_valid          (from_block_valid),
        .s_ready          (from_block_ready),
        .s_beat           (from_block_beat),
        .m_valid          (ret_mid_valid),
        .m_ready          (ret_mid_ready),
        .m_beat           (ret_mid_beat)
    );

    axi4s_reg_slice ret_slice_i (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .s_valid          (ret_mid_valid),
        .s_ready          (ret_mid_ready),
        .s_beat           (ret_mid_beat),
        .m_valid          (blk_ret_valid),
        .m_ready          (blk_ret_ready),
        .m_beat           (blk_ret_beat)
    );

    // ============================================================
    // Bypass register slice chain
    // ============================================================
    for (genvar i = 0; i < switch_cfg_pkg::BYPASS_STAGES; i++) begin : g_bp_chain
        axi4s_reg_slice bp_slice_i (
            .axi4s_if_from_tx (axi4s_if_from_tx),
            .aresetn          (aresetn),
            .s_valid          (chain_valid[i]),
            .s_ready          (chain_ready[i]),
            .s_beat           (chain_beat[i]),
            .m_valid          (chain_valid[i+1]),
            .m_ready          (chain_ready[i+1]),
            .m_beat           (chain_beat[i+1])
        );
    end

endmodule

// ==== hw/axi4s_reg_slice.sv ====
`timescale 1ns/10ps

module axi4s_reg_slice (
    input  logic                        axi4s_if_from_tx,
    input  logic                        aresetn,
    // Upstream side
    input  logic                        s_valid,
    output logic                        s_ready,
    input  axi4s_beat_pkg::axi4s_beat_t s_beat,
    // Downstream side
    output logic                        m_valid,
    input  logic                        m_ready,
    output axi4s_beat_pkg::axi4s_beat_t m_beat
);

    logic                        full;
    logic                        load;
    axi4s_beat_pkg::axi4s_beat_t beat_q;

    // Room for a new beat when empty or when the held one leaves now
    assign s_ready = !full || m_ready;
    assign load    = s_valid && s_ready;

    // Occupancy flag
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (m_ready) begin
            full <= 1'b0;
        end
    end

    // Payload register, written only on acceptance
    always_ff @(posedge axi4s_if_from_tx) begin
        if (load) begin
            beat_q <= s_beat;
        end
    end

    assign m_valid = full;
    assign m_beat  = beat_q;

endmodule

// ==== hw/axi4s_tready_slice.sv ====
`timescale 1ns/10ps

module axi4s_tready_slice (
    input  logic                        axi4s_if_from_tx,
    input  logic                        aresetn,
    // Upstream side
    input  logic                        s_valid,
    output logic                        s_ready,
    input  axi4s_beat_pkg::axi4s_beat_t s_beat,
    // Downstream side
    output logic                        m_valid,
    input  logic                        m_ready,
    output axi4s_beat_pkg::axi4s_beat_t m_beat
);

    logic                        ready_q;
    logic                        ready_falling;
    logic                        fwft;
    logic                        capture;
    logic                        skid_valid;
    axi4s_beat_pkg::axi4s_beat_t skid_beat;

    // ============================================================
    // Registered downstream ready
    // ============================================================
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= m_ready;
        end
    end

    // Upstream still sees ready for one cycle after the fall
    assign ready_falling = ready_q && !m_ready;

    // Both readies low with an empty skid, so the first beat may park there
    assign fwft = s_valid && !skid_valid && !ready_q && !m_ready;

    assign capture = ready_falling || fwft;
    assign s_ready = ready_q || fwft;

    // ============================================================
    // Skid register
    // ============================================================
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            skid_valid <= 1'b0;
        end else if (skid_valid && m_ready) begin
            skid_valid <= 1'b0;
        end else if (capture) begin
            skid_valid <= s_valid;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (capture) begin
            skid_beat <= s_beat;
        end
    end

    // ============================================================
    // Output mux
    // ============================================================
    always_comb begin
        if (skid_valid) begin
            m_valid = 1'b1;
            m_beat  = skid_beat;
        end else begin
            // Live beat only goes out while upstream is being accepted
            m_valid = s_valid && ready_q;
            m_beat  = s_beat;
        end
    end

endmodule

// ==== hw/switch_cfg_pkg.sv ====
package switch_cfg_pkg;

    // ============================================================
    // Path selection
    // ============================================================
    // Level input, only changed while the switch is idle
    typedef enum logic {
        PATH_BLOCK  = 1'b0,
        PATH_BYPASS = 1'b1
    } path_sel_e;

    // ============================================================
    // Pipeline depth
    // ============================================================
    // Register slices on the bypass path, also its latency in cycles
    localparam int BYPASS_STAGES = 2;

endpackage

// ==== sources.f ====
hw/axi4s_beat_pkg.sv
hw/switch_cfg_pkg.sv
hw/axi4s_reg_slice.sv
hw/axi4s_tready_slice.sv
hw/axi4s_bypass_switch.sv
hw/axi4s_bypass_top.sv
verification/axi4s_bypass_assertions.sv
verification/tb_axi4s_bypass.sv

// ==== verification/axi4s_bypass_assertions.sv ====
`timescale 1ns/10ps

module axi4s_bypass_assertions (
    input logic                        axi4s_if_from_tx,
    input logic                        aresetn,
    input switch_cfg_pkg::path_sel_e   bypass,
    input logic                        to_block_valid,
    input logic                        from_block_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input axi4s_beat_pkg::axi4s_beat_t out_beat,
    input logic                        out_sop
);

    // Failed assertions so far
    int fail_count = 0;

    // Stalled output keeps its beat
    out_hold_a: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("Output beat changed or dropped while stalled");
            fail_count++;
        end

    // Nothing goes to the block in bypass mode
    bypass_quiet_a: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        bypass == switch_cfg_pkg::PATH_BYPASS |-> !to_block_valid)
        else begin
            $error("to_block_valid high while the bypass path is selected");
            fail_count++;
        end

    // First cycle out of reset
    reset_idle_a: assert property (@(posedge axi4s_if_from_tx)
        $rose(aresetn) |-> !out_valid && !to_block_valid && !from_block_ready)
        else begin
            $error("Stream handshake active in the first cycle after reset");
            fail_count++;
        end

    // ============================================================
    // Start of packet
    // ============================================================
    sop_update_a: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        out_valid && out_ready |=> out_sop == $past(out_beat.tlast))
        else begin
            $error("out_sop does not follow tlast of the previous output beat");
            fail_count++;
        end

    sop_hold_a: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        !(out_valid && out_ready) |=> $stable(out_sop))
        else begin
            $error("out_sop changed without an output transfer");
            fail_count++;
        end

endmodule

// ==== verification/tb_axi4s_bypass.sv ====
`timescale 1ns/10ps

module tb_axi4s_bypass;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int BEATS_PER_TEST = 64;
    localparam int TEST_COUNT     = 4;
    // 20 cycles per beat over all tests plus a margin
    localparam int TIMEOUT_NS = 20 * TEST_COUNT * BEATS_PER_TEST * CLK_PERIOD + 2000;

    logic                        axi4s_if_from_tx;
    logic                        aresetn;
    switch_cfg_pkg::path_sel_e   bypass;
    logic                        in_valid;
    logic                        in_ready;
    axi4s_beat_pkg::axi4s_beat_t in_beat;
    logic                        to_block_valid;
    logic                        to_block_ready;
    axi4s_beat_pkg::axi4s_beat_t to_block_beat;
    logic                        from_block_valid;
    logic                        from_block_ready;
    axi4s_beat_pkg::axi4s_beat_t from_block_beat;
    logic                        out_valid;
    logic                        out_ready;
    axi4s_beat_pkg::axi4s_beat_t out_beat;
    logic                        out_sop;

    // Test control from the main sequence
    string test_name;
    bit    stall;
    int    target;

    // Stimulus side counters
    int seed;
    int issued;
    int ret_issued;

    // Scoreboard state
    axi4s_beat_pkg::axi4s_beat_t exp_q     [$];
    axi4s_beat_pkg::axi4s_beat_t blk_exp_q [$];
    axi4s_beat_pkg::axi4s_beat_t blk_store [$];
    int                          acc_q     [$];
    int                          cycle;
    int                          accepted;
    int                          returned;
    int                          received;
    bit                          exp_sop;

    axi4s_bypass_top axi4s_bypass_top_i (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_beat          (in_beat),
        .to_block_valid   (to_block_valid),
        .to_block_ready   (to_block_ready),
        .to_block_beat    (to_block_beat),
        .from_block_valid (from_block_valid),
        .from_block_ready (from_block_ready),
        .from_block_beat  (from_block_beat),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_beat         (out_beat),
        .out_sop          (out_sop)
    );

    // Protocol checks inside the DUT scope
    bind axi4s_bypass_top axi4s_bypass_assertions assertions_i (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .to_block_valid   (to_block_valid),
        .from_block_ready (from_block_ready),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_beat         (out_beat),
        .out_sop          (out_sop)
    );

    // ============================================================
    // Reporting
    // ============================================================
    task automatic report_mismatch(input string field, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("ERROR %s %s: expected %h, actual %h", test_name, field, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("Test %s: %s", test_name, reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Bound protocol checks count their failures
    always @(negedge axi4s_if_from_tx) begin
        if (axi4s_bypass_top_i.assertions_i.fail_count != 0) begin
            report_failure("a protocol assertion in the bound checker failed");
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    function automatic axi4s_beat_pkg::axi4s_beat_t random_beat();
        axi4s_beat_pkg::axi4s_beat_t beat;
        logic [31:0]                 r0;
        logic [31:0]                 r1;
        logic [31:0]                 r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        beat.tdata = {r0, r1};
        beat.tkeep = r2[7:0];
        beat.tlast = (r2[9:8] == 2'b00);  // roughly one beat in four
        beat.tid   = r2[13:10];
        beat.tdest = r2[17:14];
        beat.tuser = r2[25:18];
        return beat;
    endfunction

    // One falling edge worth of source, block model and sink activity
    task automatic drive_cycle();
        logic [31:0] r;
        r = $random(seed);
        // Source drops valid once the presented beat was taken
        if (in_valid && accepted == issued) begin
            in_valid = 1'b0;
        end
        if (!in_valid && issued < target && (!stall || r[0])) begin
            in_beat  = random_beat();
            in_valid = 1'b1;
            issued++;
        end
        // Block model returns stored beats in order
        if (from_block_valid && returned == ret_issued) begin
            from_block_valid = 1'b0;
        end
        if (!from_block_valid && ret_issued < blk_store.size() && (!stall || r[1])) begin
            from_block_beat  = blk_store[ret_issued];
            from_block_valid = 1'b1;
            ret_issued++;
        end
        out_ready      = !stall || r[2];
        to_block_ready = !stall || r[3];
    endtask

    initial begin
        axi4s_if_from_tx = 1'b1;
        forever #(CLK_PERIOD / 2) axi4s_if_from_tx = ~axi4s_if_from_tx;
    end

    initial begin
        seed             = 32'h816e;
        in_valid         = 1'b0;
        in_beat          = '0;
        to_block_ready   = 1'b1;
        from_block_valid = 1'b0;
        from_block_beat  = '0;
        out_ready        = 1'b1;
        forever begin
            @(negedge axi4s_if_from_tx);
            drive_cycle();
        end
    end

    // ============================================================
    // Scoreboard on the rising edge
    // ============================================================
    always @(posedge axi4s_if_from_tx) begin
        axi4s_beat_pkg::axi4s_beat_t exp_beat;
        axi4s_beat_pkg::axi4s_beat_t ret_beat;
        int                          acc_cycle;
        if (!aresetn) begin
            exp_sop = 1'b1;
        end else begin
            if (in_valid && in_ready) begin
                accepted++;
                if (bypass == switch_cfg_pkg::PATH_BYPASS) begin
                    exp_q.push_back(in_beat);
                    acc_q.push_back(cycle);
                end else begin
                    ret_beat       = in_beat;
                    ret_beat.tuser = ~in_beat.tuser;
                    blk_exp_q.push_back(in_beat);
                    exp_q.push_back(ret_beat);
                end
            end
            // The block inverts tuser, which marks the path a beat took
            if (to_block_valid && to_block_ready) begin
                if (blk_exp_q.size() == 0) begin
                    report_failure("a beat left on to_block while none was expected");
                end
                exp_beat = blk_exp_q.pop_front();
                assert (to_block_beat == exp_beat)
                    else report_mismatch("to_block_beat", 128'(exp_beat), 128'(to_block_beat));
                ret_beat       = to_block_beat;
                ret_beat.tuser = ~to_block_beat.tuser;
                blk_store.push_back(ret_beat);
            end
            if (from_block_valid && from_block_ready) begin
                returned++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("an output beat arrived while none was expected");
                end
                exp_beat = exp_q.pop_front();
                assert (out_beat == exp_beat)
                    else report_mismatch("out_beat", 128'(exp_beat), 128'(out_beat));
                assert (out_sop == exp_sop)
                    else report_mismatch("out_sop", 128'(exp_sop), 128'(out_sop));
                exp_sop = exp_beat.tlast;
                if (bypass == switch_cfg_pkg::PATH_BYPASS) begin
                    acc_cycle = acc_q.pop_front();
                    if (!stall) begin
                        assert (cycle - acc_cycle == switch_cfg_pkg::BYPASS_STAGES)
                            else report_mismatch("bypass latency",
                                                 128'(switch_cfg_pkg::BYPASS_STAGES),
                                                 128'(cycle - acc_cycle));
                    end
                end
                received++;
            end
        end
        cycle++;
    end

    // ============================================================
    // Main sequence
    // ============================================================
    task automatic check_idle();
        assert (out_valid == 1'b0)
            else report_mismatch("out_valid", 128'(1'b0), 128'(out_valid));
        assert (to_block_valid == 1'b0)
            else report_mismatch("to_block_valid", 128'(1'b0), 128'(to_block_valid));
        assert (from_block_ready == 1'b0)
            else report_mismatch("from_block_ready", 128'(1'b0), 128'(from_block_ready));
        assert (out_sop == 1'b1)
            else report_mismatch("out_sop", 128'(1'b1), 128'(out_sop));
    endtask

    // Select the path while idle, then release a batch of beats
    task automatic run_test(input string name, input switch_cfg_pkg::path_sel_e path,
                            input bit with_stall);
        @(negedge axi4s_if_from_tx);
        bypass = path;
        @(posedge axi4s_if_from_tx);
        test_name = name;
        stall     = with_stall;
        target    = target + BEATS_PER_TEST;
        while (received < target) begin
            @(negedge axi4s_if_from_tx);
        end
    endtask

    initial begin
        aresetn   = 1'b1;
        bypass    = switch_cfg_pkg::PATH_BLOCK;
        test_name = "reset";
        @(negedge axi4s_if_from_tx);
        aresetn = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge axi4s_if_from_tx);
            check_idle();
        end
        @(negedge axi4s_if_from_tx);
        aresetn = 1'b1;
        @(posedge axi4s_if_from_tx);
        check_idle();

        run_test("bypass", switch_cfg_pkg::PATH_BYPASS, 1'b0);
        run_test("block", switch_cfg_pkg::PATH_BLOCK, 1'b0);
        run_test("bypass_stall", switch_cfg_pkg::PATH_BYPASS, 1'b1);
        run_test("block_stall", switch_cfg_pkg::PATH_BLOCK, 1'b1);

        @(negedge axi4s_if_from_tx);
        if (exp_q.size() == 0 && blk_exp_q.size() == 0 && returned == blk_store.size()) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Beats were still pending in the scoreboard at the end of the run");
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $fatal(1);
    end

endmodule
